//--- Makefile
# Verilator build and run for the TCB subsystem testbench

ALIGNED ?= 1

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -GALIGNED=$(ALIGNED) \
		--top-module tcb_tb -f project.f -o Vtcb_tb

run: compile
	@out="$$(./obj_dir/Vtcb_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Finished with no errors'

clean:
	rm -rf obj_dir

//--- project.f
+incdir+testbench
src/tcb_pkg.sv
src/tcb_lib_logsize2byteena.sv
src/tcb_mem_ben.sv
src/tcb_top.sv
testbench/tcb_tb.sv

//--- src/tcb_lib_logsize2byteena.sv
// TCB log size to byte enable converter

`timescale 1ns/1ns

module tcb_lib_logsize2byteena #(
  // aligned only variant is smaller, unaligned one rotates lanes
  parameter bit ALIGNED = 1'b1
)(
  // system
  input  logic                            clk,
  input  logic                            rst_n,
  // manager side, log size mode
  input  logic                            req_vld,
  input  logic                            req_wen,
  input  logic [tcb_pkg::ADR_WIDTH-1:0]   req_adr,
  input  logic [tcb_pkg::SIZ_WIDTH-1:0]   req_siz,
  input  logic [tcb_pkg::DAT_WIDTH-1:0]   req_wdt,
  output logic                            req_rdy,
  output logic [tcb_pkg::DAT_WIDTH-1:0]   rsp_rdt,
  output logic                            rsp_sts,
  // memory side, byte enable mode
  output logic                            mem_vld,
  output logic                            mem_wen,
  output logic [tcb_pkg::ADR_WIDTH-1:0]   mem_adr,
  output logic [tcb_pkg::BUS_BEN-1:0]     mem_ben,
  output logic [tcb_pkg::DAT_WIDTH-1:0]   mem_wdt,
  input  logic                            mem_rdy,
  input  logic [tcb_pkg::DAT_WIDTH-1:0]   mem_rdt,
  input  logic                            mem_sts
);

  //////////////////////////////////////////////////////////////////////
  // pass through
  //////////////////////////////////////////////////////////////////////

  // handshake
  assign mem_vld = req_vld;
  assign req_rdy = mem_rdy;

  // address and direction unchanged
  assign mem_adr = req_adr;
  assign mem_wen = req_wen;

  // status straight from memory
  assign rsp_sts = mem_sts;

  //////////////////////////////////////////////////////////////////////
  // offsets
  //////////////////////////////////////////////////////////////////////

  // request offset, current cycle
  logic [tcb_pkg::BUS_MAX-1:0] req_off;
  // response offset, delayed by HSK_DLY
  logic [tcb_pkg::BUS_MAX-1:0] rsp_off;
  // offset delay line
  logic [tcb_pkg::BUS_MAX-1:0] off_dly [tcb_pkg::HSK_DLY];

  // low address bits select the lane
  assign req_off = req_adr[tcb_pkg::BUS_MAX-1:0];

  // first stage loads on handshake, the rest shift
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int unsigned i = 0; i < tcb_pkg::HSK_DLY; i++) begin
        off_dly[i] <= '0;
      end
    end else begin
      if (req_vld && req_rdy) begin
        off_dly[0] <= req_off;
      end
      for (int unsigned i = 1; i < tcb_pkg::HSK_DLY; i++) begin
        off_dly[i] <= off_dly[i-1];
      end
    end
  end

  // last stage lines up with the response
  assign rsp_off = off_dly[tcb_pkg::HSK_DLY-1];

  // prefix OR from msb down
  function automatic logic [tcb_pkg::BUS_MAX-1:0] prefix_or(
    input logic [tcb_pkg::BUS_MAX-1:0] val
  );
    prefix_or[tcb_pkg::BUS_MAX-1] = val[tcb_pkg::BUS_MAX-1];
    for (int unsigned i = tcb_pkg::BUS_MAX-1; i > 0; i--) begin
      prefix_or[i-1] = prefix_or[i] | val[i-1];
    end
  endfunction: prefix_or

  //////////////////////////////////////////////////////////////////////
  // lane multiplexers
  //////////////////////////////////////////////////////////////////////

  generate
  if (ALIGNED) begin: aligned

    // offset bits that matter for this size
    logic [tcb_pkg::BUS_MAX-1:0] req_msk;

    // mask bits at or above the size code
    always_comb begin
      for (int unsigned i = 0; i < tcb_pkg::BUS_MAX; i++) begin
        req_msk[i] = (i >= req_siz);
      end
    end

    // lane enabled when masked index matches masked offset
    always_comb begin
      for (int unsigned i = 0; i < tcb_pkg::BUS_BEN; i++) begin
        mem_ben[i] = (req_off & req_msk) == (i[tcb_pkg::BUS_MAX-1:0] & req_msk);
      end
    end

    // replicate the low write bytes over the lanes
    always_comb begin
      logic [tcb_pkg::BUS_MAX-1:0] sel;
      for (int unsigned i = 0; i < tcb_pkg::BUS_BEN; i++) begin
        sel = i[tcb_pkg::BUS_MAX-1:0] & ~req_msk;
        mem_wdt[8*i +: 8] = req_wdt[8*sel +: 8];
      end
    end

    // pick the addressed lanes back into the low bytes
    always_comb begin
      logic [tcb_pkg::BUS_MAX-1:0] sel;
      for (int unsigned i = 0; i < tcb_pkg::BUS_BEN; i++) begin
        sel = (~prefix_or(i[tcb_pkg::BUS_MAX-1:0]) & rsp_off) | i[tcb_pkg::BUS_MAX-1:0];
        rsp_rdt[8*i +: 8] = mem_rdt[8*sel +: 8];
      end
    end

  end: aligned
  else begin: unaligned

    // enables before rotation, low 2**siz bytes
    logic [tcb_pkg::BUS_BEN-1:0] siz_ben;

    always_comb begin
      for (int unsigned i = 0; i < tcb_pkg::BUS_BEN; i++) begin
        siz_ben[i] = (i < (1 << req_siz));
      end
    end

    // rotate enables and write data up by the offset
    // 2-bit index wraps modulo BUS_BEN
    always_comb begin
      logic [tcb_pkg::BUS_MAX-1:0] sel;
      for (int unsigned i = 0; i < tcb_pkg::BUS_BEN; i++) begin
        sel = i[tcb_pkg::BUS_MAX-1:0] - req_off;
        mem_ben[i]        = siz_ben[sel];
        mem_wdt[8*i +: 8] = req_wdt[8*sel +: 8];
      end
    end

    // rotate read data back down
    always_comb begin
      logic [tcb_pkg::BUS_MAX-1:0] sel;
      for (int unsigned i = 0; i < tcb_pkg::BUS_BEN; i++) begin
        sel = i[tcb_pkg::BUS_MAX-1:0] + rsp_off;
        rsp_rdt[8*i +: 8] = mem_rdt[8*sel +: 8];
      end
    end

  end: unaligned
  endgenerate

endmodule: tcb_lib_logsize2byteena

//--- src/tcb_mem_ben.sv
// TCB byte enable memory

`timescale 1ns/1ns

module tcb_mem_ben (
  // system
  input  logic                            clk,
  input  logic                            rst_n,
  // request
  input  logic                            mem_vld,
  input  logic                            mem_wen,
  input  logic [tcb_pkg::ADR_WIDTH-1:0]   mem_adr,
  input  logic [tcb_pkg::BUS_BEN-1:0]     mem_ben,
  input  logic [tcb_pkg::DAT_WIDTH-1:0]   mem_wdt,
  output logic                            mem_rdy,
  // response
  output logic [tcb_pkg::DAT_WIDTH-1:0]   mem_rdt,
  output logic                            mem_sts
);

  //////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////

  // storage, one word per entry
  logic [tcb_pkg::DAT_WIDTH-1:0] mem_array [tcb_pkg::MEM_DEPTH];

  // handshake this cycle
  logic hsk;
  // word index into the array
  logic [tcb_pkg::MEM_AWIDTH-1:0] word_adr;
  // address above array range
  logic adr_err;

  assign hsk      = mem_vld & mem_rdy;
  assign word_adr = mem_adr[tcb_pkg::BUS_MAX +: tcb_pkg::MEM_AWIDTH];
  assign adr_err  = |mem_adr[tcb_pkg::ADR_WIDTH-1:tcb_pkg::BUS_MAX+tcb_pkg::MEM_AWIDTH];

  //////////////////////////////////////////////////////////////////////
  // ready
  //////////////////////////////////////////////////////////////////////

  // low in reset, high from first clock after release
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_rdy <= 1'b0;
    end else begin
      mem_rdy <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // array access
  //////////////////////////////////////////////////////////////////////

  // byte write, only enabled lanes, not on error
  always_ff @(posedge clk) begin
    if (hsk && mem_wen && !adr_err) begin
      for (int unsigned i = 0; i < tcb_pkg::BUS_BEN; i++) begin
        if (mem_ben[i]) begin
          mem_array[word_adr][8*i +: 8] <= mem_wdt[8*i +: 8];
        end
      end
    end
  end

  // full word read, zero when out of range
  always_ff @(posedge clk) begin
    if (hsk && !mem_wen) begin
      mem_rdt <= adr_err ? '0 : mem_array[word_adr];
    end
  end

  // error status for one response cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_sts <= tcb_pkg::STS_OK;
    end else begin
      mem_sts <= (hsk && adr_err) ? tcb_pkg::STS_ERR : tcb_pkg::STS_OK;
    end
  end

endmodule: tcb_mem_ben

//--- src/tcb_pkg.sv
// TCB subsystem shared definitions

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus geometry
  //////////////////////////////////////////////////////////////////////

  // byte address width
  localparam int unsigned ADR_WIDTH = 12;

  // data bus width
  localparam int unsigned DAT_WIDTH = 32;

  // byte lanes on the data bus
  localparam int unsigned BUS_BEN = DAT_WIDTH / 8;

  // address offset bits within a word
  localparam int unsigned BUS_MAX = $clog2(BUS_BEN);

  // log size code width
  // 0 -> byte, 1 -> halfword, 2 -> word
  localparam int unsigned SIZ_WIDTH = 2;

  //////////////////////////////////////////////////////////////////////
  // memory geometry
  //////////////////////////////////////////////////////////////////////

  // number of words in the memory array
  localparam int unsigned MEM_DEPTH = 256;

  // word address bits used by the array
  localparam int unsigned MEM_AWIDTH = $clog2(MEM_DEPTH);

  //////////////////////////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////////////////////////

  // response status values
  localparam logic STS_OK  = 1'b0;
  localparam logic STS_ERR = 1'b1;

  // cycles from request handshake to response
  localparam int unsigned HSK_DLY = 1;

endpackage: tcb_pkg

//--- src/tcb_top.sv
// TCB converter and memory subsystem

`timescale 1ns/1ns

module tcb_top #(
  // converter variant, 1 aligned only
  parameter bit ALIGNED = 1'b1
)(
  // system
  input  logic                            clk,
  input  logic                            rst_n,
  // manager request, log size mode
  input  logic                            req_vld,
  input  logic                            req_wen,
  input  logic [tcb_pkg::ADR_WIDTH-1:0]   req_adr,
  input  logic [tcb_pkg::SIZ_WIDTH-1:0]   req_siz,
  input  logic [tcb_pkg::DAT_WIDTH-1:0]   req_wdt,
  output logic                            req_rdy,
  // manager response
  output logic [tcb_pkg::DAT_WIDTH-1:0]   rsp_rdt,
  output logic                            rsp_sts
);

  //////////////////////////////////////////////////////////////////////
  // converter to memory bus
  //////////////////////////////////////////////////////////////////////

  // byte enable mode request
  logic                          mem_vld;
  logic                          mem_wen;
  logic [tcb_pkg::ADR_WIDTH-1:0] mem_adr;
  logic [tcb_pkg::BUS_BEN-1:0]   mem_ben;
  logic [tcb_pkg::DAT_WIDTH-1:0] mem_wdt;
  // memory handshake and response
  logic                          mem_rdy;
  logic [tcb_pkg::DAT_WIDTH-1:0] mem_rdt;
  logic                          mem_sts;

  // log size to byte enable
  tcb_lib_logsize2byteena #(
    .ALIGNED (ALIGNED)
  ) conv0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req_wen (req_wen),
    .req_adr (req_adr),
    .req_siz (req_siz),
    .req_wdt (req_wdt),
    .req_rdy (req_rdy),
    .rsp_rdt (rsp_rdt),
    .rsp_sts (rsp_sts),
    .mem_vld (mem_vld),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rdy (mem_rdy),
    .mem_rdt (mem_rdt),
    .mem_sts (mem_sts)
  );

  // word memory with byte writes
  tcb_mem_ben mem0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .mem_vld (mem_vld),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rdy (mem_rdy),
    .mem_rdt (mem_rdt),
    .mem_sts (mem_sts)
  );

endmodule: tcb_top

//--- testbench/tcb_tb_ref.svh
// TCB testbench reference model

`ifndef TCB_TB_REF_SVH
`define TCB_TB_REF_SVH

// byte-wide copy of the memory contents
logic [7:0] shadow [tcb_pkg::MEM_DEPTH*tcb_pkg::BUS_BEN];

// no address bits above the array
function automatic logic adr_in_range(input logic [tcb_pkg::ADR_WIDTH-1:0] adr);
  return adr < tcb_pkg::MEM_DEPTH * tcb_pkg::BUS_BEN;
endfunction

// lane of byte i of an access, wraps within the word
function automatic int unsigned lane_of(
  input logic [tcb_pkg::ADR_WIDTH-1:0] adr,
  input int unsigned                   i
);
  return (adr % tcb_pkg::BUS_BEN + i) % tcb_pkg::BUS_BEN;
endfunction

// shadow entry of byte i
function automatic int unsigned shadow_idx(
  input logic [tcb_pkg::ADR_WIDTH-1:0] adr,
  input int unsigned                   i
);
  return (adr / tcb_pkg::BUS_BEN) % tcb_pkg::MEM_DEPTH * tcb_pkg::BUS_BEN + lane_of(adr, i);
endfunction

// lanes enabled for 2**siz bytes
function automatic logic [tcb_pkg::BUS_BEN-1:0] ben_exp(
  input logic [tcb_pkg::ADR_WIDTH-1:0] adr,
  input logic [tcb_pkg::SIZ_WIDTH-1:0] siz
);
  logic [tcb_pkg::BUS_BEN-1:0] ben;
  ben = '0;
  for (int unsigned i = 0; i < (1 << siz); i++) begin
    ben[lane_of(adr, i)] = 1'b1;
  end
  return ben;
endfunction

// low 2**siz bytes of a data word
function automatic logic [tcb_pkg::DAT_WIDTH-1:0] size_mask(
  input logic [tcb_pkg::SIZ_WIDTH-1:0] siz
);
  return {tcb_pkg::DAT_WIDTH{1'b1}} >> (tcb_pkg::DAT_WIDTH - 8 * (1 << siz));
endfunction

// low write bytes land on their lanes
function automatic void shadow_write(
  input logic [tcb_pkg::ADR_WIDTH-1:0] adr,
  input logic [tcb_pkg::SIZ_WIDTH-1:0] siz,
  input logic [tcb_pkg::DAT_WIDTH-1:0] wdt
);
  for (int unsigned i = 0; i < (1 << siz); i++) begin
    shadow[shadow_idx(adr, i)] = wdt[8*i +: 8];
  end
endfunction

// addressed bytes gathered into the low lanes
function automatic logic [tcb_pkg::DAT_WIDTH-1:0] shadow_read(
  input logic [tcb_pkg::ADR_WIDTH-1:0] adr,
  input logic [tcb_pkg::SIZ_WIDTH-1:0] siz
);
  logic [tcb_pkg::DAT_WIDTH-1:0] rdt;
  rdt = '0;
  for (int unsigned i = 0; i < (1 << siz); i++) begin
    rdt[8*i +: 8] = shadow[shadow_idx(adr, i)];
  end
  return rdt;
endfunction

`endif

//--- testbench/tcb_tb.sv
// TCB subsystem testbench

`timescale 1ns/1ns

module tcb_tb #(
  parameter bit ALIGNED = 1'b1
);

  // sequence lengths with 14 aligned and 12 misaligned transfers per group
  localparam int unsigned RST_CYCLES = 8;
  localparam int unsigned N_RAND     = 32;
  localparam int unsigned N_GRP      = 8;
  localparam int unsigned SEQ_CYCLES = RST_CYCLES + 1 + tcb_pkg::MEM_DEPTH + 2 * N_RAND
                                       + N_GRP * (14 + 12) + 6;
  localparam int unsigned CYC_LIMIT  = 2 * SEQ_CYCLES;

  // DUT ports
  logic                          clk;
  logic                          rst_n;
  logic                          req_vld;
  logic                          req_wen;
  logic [tcb_pkg::ADR_WIDTH-1:0] req_adr;
  logic [tcb_pkg::SIZ_WIDTH-1:0] req_siz;
  logic [tcb_pkg::DAT_WIDTH-1:0] req_wdt;
  logic                          req_rdy;
  logic [tcb_pkg::DAT_WIDTH-1:0] rsp_rdt;
  logic                          rsp_sts;

  // response shown now and checked at the next rising edge
  logic                          chk_vld;
  logic                          chk_sts;
  logic [tcb_pkg::DAT_WIDTH-1:0] chk_rdt;
  logic [tcb_pkg::DAT_WIDTH-1:0] chk_msk;
  // response of the request in flight
  logic                          pnd_vld;
  logic                          pnd_sts;
  logic [tcb_pkg::DAT_WIDTH-1:0] pnd_rdt;
  logic [tcb_pkg::DAT_WIDTH-1:0] pnd_msk;

  int unsigned err_rdt;
  int unsigned err_sts;
  int unsigned err_ben;
  int unsigned err_rdy;
  int unsigned cyc;
  integer      seed;

  `include "tcb_tb_ref.svh"

  tcb_top #(.ALIGNED(ALIGNED)) dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // read data in the low 2**siz bytes only
  rdt_check: assert property (@(posedge clk) disable iff (!rst_n)
    chk_vld |-> ((rsp_rdt & chk_msk) == chk_rdt))
  else begin
    err_rdt++;
    $display("[FAIL] rsp_rdt expected %h actual %h", chk_rdt, $sampled(rsp_rdt) & chk_msk);
  end

  // status for reads and writes
  sts_check: assert property (@(posedge clk) disable iff (!rst_n)
    chk_vld |-> (rsp_sts == chk_sts))
  else begin
    err_sts++;
    $display("[FAIL] rsp_sts expected %h actual %h", chk_sts, $sampled(rsp_sts));
  end

  // converter lane enables toward the memory
  ben_check: assert property (@(posedge clk) disable iff (!rst_n)
    req_vld |-> (dut0.mem_ben == ben_exp(req_adr, req_siz)))
  else begin
    err_ben++;
    $display("[FAIL] mem_ben expected %h actual %h", ben_exp(req_adr, req_siz), dut0.mem_ben);
  end

  // run length guard
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc == CYC_LIMIT) begin
      $display("timeout, the run did not finish within %0d cycles", CYC_LIMIT);
      $display("Finished with errors");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // byte address of word w plus offset
  function automatic logic [tcb_pkg::ADR_WIDTH-1:0] word_adr(input int unsigned w,
                                                             input int unsigned off);
    return w * tcb_pkg::BUS_BEN + off;
  endfunction

  // one bus cycle from a falling edge
  // vld low gives an idle cycle
  task automatic transfer(input logic vld, input logic wen,
                          input logic [tcb_pkg::ADR_WIDTH-1:0] adr,
                          input logic [tcb_pkg::SIZ_WIDTH-1:0] siz,
                          input logic [tcb_pkg::DAT_WIDTH-1:0] wdt);
    // previous response shows during the coming cycle
    chk_vld = pnd_vld;
    chk_sts = pnd_sts;
    chk_rdt = pnd_rdt;
    chk_msk = pnd_msk;
    req_vld = vld;
    req_wen = wen;
    req_adr = adr;
    req_siz = siz;
    req_wdt = wdt;
    // request held while not ready
    // the old response lasts one cycle
    while (vld && !req_rdy) begin
      @(negedge clk);
      chk_vld = 1'b0;
    end
    pnd_vld = vld;
    pnd_sts = adr_in_range(adr) ? tcb_pkg::STS_OK : tcb_pkg::STS_ERR;
    pnd_msk = wen ? '0 : (adr_in_range(adr) ? size_mask(siz) : '1);
    pnd_rdt = (wen || !adr_in_range(adr)) ? '0 : shadow_read(adr, siz);
    if (vld && wen && adr_in_range(adr)) begin
      shadow_write(adr, siz, wdt);
    end
    @(negedge clk);
  endtask

  initial begin
    int unsigned w;
    int unsigned wrd_q [N_RAND];
    logic [31:0] rnd;
    seed    = 32'had5595dc;
    err_rdt = 0;
    err_sts = 0;
    err_ben = 0;
    err_rdy = 0;
    cyc     = 0;
    rst_n   = 1'b0;
    req_vld = 1'b0;
    req_wen = 1'b0;
    req_adr = '0;
    req_siz = '0;
    req_wdt = '0;
    chk_vld = 1'b0;
    pnd_vld = 1'b0;

    // ready low and status ok while reset is held
    repeat (RST_CYCLES) begin
      @(negedge clk);
      assert (req_rdy == 1'b0)
      else begin
        err_rdy++;
        $display("[FAIL] req_rdy expected %h actual %h", 1'b0, req_rdy);
      end
      assert (rsp_sts == tcb_pkg::STS_OK)
      else begin
        err_sts++;
        $display("[FAIL] rsp_sts expected %h actual %h", tcb_pkg::STS_OK, rsp_sts);
      end
    end
    rst_n = 1'b1;
    @(negedge clk);
    assert (req_rdy == 1'b1)
    else begin
      err_rdy++;
      $display("[FAIL] req_rdy expected %h actual %h", 1'b1, req_rdy);
    end

    // fill every word with a pattern from the whole word address
    for (int unsigned i = 0; i < tcb_pkg::MEM_DEPTH; i++) begin
      transfer(1'b1, 1'b1, word_adr(i, 0), 2'd2,
               {8'(i) ^ 8'hc3, ~8'(i), 8'(i) + 8'h5a, 8'(i)});
    end

    // random word writes then back-to-back reads
    for (int unsigned k = 0; k < N_RAND; k++) begin
      rnd      = $random(seed);
      wrd_q[k] = rnd % tcb_pkg::MEM_DEPTH;
      transfer(1'b1, 1'b1, word_adr(wrd_q[k], 0), 2'd2, $random(seed));
    end
    for (int unsigned k = 0; k < N_RAND; k++) begin
      transfer(1'b1, 1'b0, word_adr(wrd_q[k], 0), 2'd2, '0);
    end

    // bytes and halfwords at every aligned offset
    for (int unsigned g = 0; g < N_GRP; g++) begin
      rnd = $random(seed);
      w   = rnd % tcb_pkg::MEM_DEPTH;
      for (int unsigned o = 0; o < tcb_pkg::BUS_BEN; o++) begin
        transfer(1'b1, 1'b1, word_adr(w, o), 2'd0, $random(seed));
      end
      transfer(1'b1, 1'b0, word_adr(w, 0), 2'd2, '0);
      for (int unsigned o = 0; o < tcb_pkg::BUS_BEN; o++) begin
        transfer(1'b1, 1'b0, word_adr(w, o), 2'd0, '0);
      end
      for (int unsigned o = 0; o < tcb_pkg::BUS_BEN; o += 2) begin
        transfer(1'b1, 1'b1, word_adr(w, o), 2'd1, $random(seed));
      end
      transfer(1'b1, 1'b0, word_adr(w, 0), 2'd2, '0);
      for (int unsigned o = 0; o < tcb_pkg::BUS_BEN; o += 2) begin
        transfer(1'b1, 1'b0, word_adr(w, o), 2'd1, '0);
      end
    end

    // misaligned halfwords and words wrap within the word
    if (!ALIGNED) begin
      for (int unsigned g = 0; g < N_GRP; g++) begin
        rnd = $random(seed);
        w   = rnd % tcb_pkg::MEM_DEPTH;
        for (int unsigned o = 1; o < tcb_pkg::BUS_BEN; o += 2) begin
          transfer(1'b1, 1'b1, word_adr(w, o), 2'd1, $random(seed));
        end
        transfer(1'b1, 1'b0, word_adr(w, 0), 2'd2, '0);
        for (int unsigned o = 1; o < tcb_pkg::BUS_BEN; o += 2) begin
          transfer(1'b1, 1'b0, word_adr(w, o), 2'd1, '0);
        end
        for (int unsigned o = 1; o < tcb_pkg::BUS_BEN; o++) begin
          transfer(1'b1, 1'b1, word_adr(w, o), 2'd2, $random(seed));
        end
        transfer(1'b1, 1'b0, word_adr(w, 0), 2'd2, '0);
        for (int unsigned o = 1; o < tcb_pkg::BUS_BEN; o++) begin
          transfer(1'b1, 1'b0, word_adr(w, o), 2'd2, '0);
        end
      end
    end

    // out of range accesses alias word w which must stay unchanged
    rnd = $random(seed);
    w   = rnd % tcb_pkg::MEM_DEPTH;
    transfer(1'b1, 1'b0, word_adr(w + 3 * tcb_pkg::MEM_DEPTH, 0), 2'd2, '0);
    transfer(1'b1, 1'b1, word_adr(w + tcb_pkg::MEM_DEPTH, 0), 2'd2, $random(seed));
    transfer(1'b1, 1'b0, word_adr(w + 2 * tcb_pkg::MEM_DEPTH, 1), 2'd0, '0);
    transfer(1'b1, 1'b0, word_adr(w, 0), 2'd2, '0);
    // drain the last response
    transfer(1'b0, 1'b0, '0, 2'd0, '0);
    transfer(1'b0, 1'b0, '0, 2'd0, '0);

    $display("errors: rsp_rdt %0d, rsp_sts %0d, mem_ben %0d, req_rdy %0d",
             err_rdt, err_sts, err_ben, err_rdy);
    if (err_rdt + err_sts + err_ben + err_rdy == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule: tcb_tb
